// ==== verilog/hss_mux_pkg.sv ====
// Shared definitions for the eight-channel serial link multiplexer
// Link, packet and FIFO sizes
// Header and idle word encodings
// Vector types and the framing FSM state encodings

`default_nettype none

package hss_mux_pkg;

  ////////////////////
  // Sizes
  ////////////////////

  localparam int NUM_CHANS  = 8;
  localparam int CHAN_BITS  = 3;
  localparam int PKT_BITS   = 64;
  localparam int WORD_BITS  = 32;
  localparam int KFLAG_BITS = 4;
  localparam int FIFO_DEPTH = 4;

  ////////////////////
  // Frame encoding
  ////////////////////

  // K28.5 comma in byte 0 of header and idle words
  localparam logic [7:0] COMMA_BYTE = 8'hBC;
  // Byte 1 of an idle word, never a valid channel index
  localparam logic [7:0] IDLE_TAG = 8'hF0;
  // Only byte 0 carries a K character
  localparam logic [KFLAG_BITS-1:0] HDR_KFLAGS = 4'b0001;

  ////////////////////
  // Types
  ////////////////////

  typedef logic [PKT_BITS-1:0]   pkt_t;
  typedef logic [CHAN_BITS-1:0]  chan_t;
  typedef logic [WORD_BITS-1:0]  word_t;
  typedef logic [KFLAG_BITS-1:0] kflag_t;

  // Transmit framing FSM
  typedef enum logic [1:0] {ASM_IDLE, ASM_HDR, ASM_W0, ASM_W1} asm_state_t;

  // Receive framing FSM
  typedef enum logic [1:0] {DIS_HUNT, DIS_W0, DIS_W1} dis_state_t;

endpackage

`default_nettype wire

// ==== verilog/pkt_fifo.sv ====
// Packet FIFO with valid/ready handshakes on both sides
// Circular buffer with read and write pointers and an occupancy count

`timescale 1ns/1ps
`default_nettype none

module pkt_fifo #(
  parameter int DEPTH = hss_mux_pkg::FIFO_DEPTH
) (
  input  wire                     clk_i,
  input  wire                     rst_n_i,
  // Write side
  input  wire hss_mux_pkg::pkt_t  in_data_i,
  input  wire                     in_vld_i,
  output logic                    in_rdy_o,
  // Read side
  output hss_mux_pkg::pkt_t       out_data_o,
  output logic                    out_vld_o,
  input  wire                     out_rdy_i
);

  hss_mux_pkg::pkt_t mem [DEPTH];

  logic [$clog2(DEPTH)-1:0] wr_ptr;
  logic [$clog2(DEPTH)-1:0] rd_ptr;
  logic [$clog2(DEPTH):0]   count;

  logic push;
  logic pop;

  // Full and empty straight from the count
  assign in_rdy_o   = (count != ($clog2(DEPTH)+1)'(DEPTH));
  assign out_vld_o  = (count != '0);
  assign out_data_o = mem[rd_ptr];

  assign push = in_vld_i & in_rdy_o;
  assign pop  = out_vld_o & out_rdy_i;

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr] <= in_data_i;
    end
  end

  // Pointers wrap naturally since DEPTH is a power of two
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Occupancy never passes DEPTH and matches the pointer distance
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (count <= ($clog2(DEPTH)+1)'(DEPTH)) &&
    ((wr_ptr - rd_ptr) == count[$clog2(DEPTH)-1:0]));

endmodule

`default_nettype wire

// ==== verilog/frame_assembler.sv ====
// Transmit side of the link
// Round-robin arbiter over the channel FIFOs
// Serialiser of each packet into a header word and two data words

`timescale 1ns/1ps
`default_nettype none

module frame_assembler (
  input  wire                          clk_i,
  input  wire                          rst_n_i,
  // Channel FIFO outputs
  input  wire hss_mux_pkg::pkt_t       chan_data_i [hss_mux_pkg::NUM_CHANS],
  input  wire [hss_mux_pkg::NUM_CHANS-1:0] chan_vld_i,
  output logic [hss_mux_pkg::NUM_CHANS-1:0] chan_rdy_o,
  // Link words
  output hss_mux_pkg::word_t           tx_data_o,
  output hss_mux_pkg::kflag_t          tx_kflags_o
);

  hss_mux_pkg::asm_state_t state;
  hss_mux_pkg::chan_t      rr_ptr;
  hss_mux_pkg::chan_t      chan_q;
  hss_mux_pkg::pkt_t       pkt_q;

  hss_mux_pkg::chan_t grant_chan;
  logic               grant_found;
  logic               pop_en;

  ////////////////////
  // Arbitration
  ////////////////////

  // First valid channel after the last one served, wrapping
  always_comb begin
    hss_mux_pkg::chan_t idx;
    grant_found = 1'b0;
    grant_chan  = '0;
    idx         = '0;
    for (int i = hss_mux_pkg::NUM_CHANS; i >= 1; i--) begin
      idx = rr_ptr + hss_mux_pkg::chan_t'(i);
      if (chan_vld_i[idx]) begin
        grant_found = 1'b1;
        grant_chan  = idx;
      end
    end
  end

  // A new packet may be taken while idle or on the last data word
  assign pop_en = grant_found &&
                  (state == hss_mux_pkg::ASM_IDLE || state == hss_mux_pkg::ASM_W1);

  always_comb begin
    chan_rdy_o = '0;
    if (pop_en) begin
      chan_rdy_o[grant_chan] = 1'b1;
    end
  end

  ////////////////////
  // Framing FSM
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state  <= hss_mux_pkg::ASM_IDLE;
      rr_ptr <= hss_mux_pkg::chan_t'(hss_mux_pkg::NUM_CHANS - 1);
    end else begin
      case (state)
        hss_mux_pkg::ASM_HDR: state <= hss_mux_pkg::ASM_W0;
        hss_mux_pkg::ASM_W0:  state <= hss_mux_pkg::ASM_W1;
        default: begin
          // ASM_IDLE and ASM_W1 share the pop decision
          state <= pop_en ? hss_mux_pkg::ASM_HDR : hss_mux_pkg::ASM_IDLE;
        end
      endcase
      if (pop_en) begin
        rr_ptr <= grant_chan;
      end
    end
  end

  // Packet and channel latched on the pop
  always_ff @(posedge clk_i) begin
    if (pop_en) begin
      pkt_q  <= chan_data_i[grant_chan];
      chan_q <= grant_chan;
    end
  end

  // Word mux
  always_comb begin
    case (state)
      hss_mux_pkg::ASM_HDR: begin
        tx_data_o   = {16'h0000, {(8 - hss_mux_pkg::CHAN_BITS){1'b0}}, chan_q,
                       hss_mux_pkg::COMMA_BYTE};
        tx_kflags_o = hss_mux_pkg::HDR_KFLAGS;
      end
      hss_mux_pkg::ASM_W0: begin
        tx_data_o   = pkt_q[hss_mux_pkg::PKT_BITS-1:hss_mux_pkg::WORD_BITS];
        tx_kflags_o = '0;
      end
      hss_mux_pkg::ASM_W1: begin
        tx_data_o   = pkt_q[hss_mux_pkg::WORD_BITS-1:0];
        tx_kflags_o = '0;
      end
      default: begin
        tx_data_o   = {16'h0000, hss_mux_pkg::IDLE_TAG, hss_mux_pkg::COMMA_BYTE};
        tx_kflags_o = hss_mux_pkg::HDR_KFLAGS;
      end
    endcase
  end

  a_rdy_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(chan_rdy_o));

  // The header after a pop names the granted channel
  a_hdr_chan: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop_en |=> (tx_kflags_o == hss_mux_pkg::HDR_KFLAGS &&
                tx_data_o[8 +: hss_mux_pkg::CHAN_BITS] == $past(grant_chan)));

endmodule

`default_nettype wire

// ==== verilog/frame_disassembler.sv ====
// Receive side of the link
// Frame parser for header, data and idle words
// Steering of complete packets to the channel FIFOs, with a drop counter

`timescale 1ns/1ps
`default_nettype none

module frame_disassembler (
  input  wire                          clk_i,
  input  wire                          rst_n_i,
  // Link words
  input  wire hss_mux_pkg::word_t      rx_data_i,
  input  wire hss_mux_pkg::kflag_t     rx_kflags_i,
  input  wire                          rx_loss_of_sync_i,
  // Receive FIFO inputs, data shared by all channels
  output hss_mux_pkg::pkt_t            chan_data_o,
  output logic [hss_mux_pkg::NUM_CHANS-1:0] chan_vld_o,
  input  wire [hss_mux_pkg::NUM_CHANS-1:0]  chan_rdy_i,
  output logic [15:0]                  drop_cnt_o
);

  hss_mux_pkg::dis_state_t state;
  hss_mux_pkg::chan_t      chan_q;
  hss_mux_pkg::word_t      hi_q;
  hss_mux_pkg::word_t      lo_q;
  logic                    push_pend;

  logic is_comma;
  logic is_hdr;
  logic is_data;

  ////////////////////
  // Word decode
  ////////////////////

  assign is_comma = (rx_kflags_i == hss_mux_pkg::HDR_KFLAGS) &&
                    (rx_data_i[7:0] == hss_mux_pkg::COMMA_BYTE);
  // Channel byte in range and upper bytes clear
  assign is_hdr   = is_comma && (rx_data_i[31:16] == 16'h0000) &&
                    (rx_data_i[15:8] < hss_mux_pkg::NUM_CHANS);
  assign is_data  = (rx_kflags_i == '0);

  // Idle words and anything unexpected fall back to the hunt

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state     <= hss_mux_pkg::DIS_HUNT;
      push_pend <= 1'b0;
    end else begin
      push_pend <= 1'b0;
      if (rx_loss_of_sync_i) begin
        state <= hss_mux_pkg::DIS_HUNT;
      end else if (is_hdr) begin
        // A header always opens a new frame
        state <= hss_mux_pkg::DIS_W0;
      end else begin
        case (state)
          hss_mux_pkg::DIS_W0: begin
            state <= is_data ? hss_mux_pkg::DIS_W1 : hss_mux_pkg::DIS_HUNT;
          end
          hss_mux_pkg::DIS_W1: begin
            state     <= hss_mux_pkg::DIS_HUNT;
            push_pend <= is_data;
          end
          default: state <= hss_mux_pkg::DIS_HUNT;
        endcase
      end
    end
  end

  // Channel and halves captured as they pass
  always_ff @(posedge clk_i) begin
    if (!rx_loss_of_sync_i && is_hdr) begin
      chan_q <= rx_data_i[8 +: hss_mux_pkg::CHAN_BITS];
    end
    if (!rx_loss_of_sync_i && is_data && state == hss_mux_pkg::DIS_W0) begin
      hi_q <= rx_data_i;
    end
    if (!rx_loss_of_sync_i && is_data && state == hss_mux_pkg::DIS_W1) begin
      lo_q <= rx_data_i;
    end
  end

  ////////////////////
  // Steering
  ////////////////////

  assign chan_data_o = {hi_q, lo_q};

  always_comb begin
    chan_vld_o = '0;
    if (push_pend && chan_rdy_i[chan_q]) begin
      chan_vld_o[chan_q] = 1'b1;
    end
  end

  // Full target FIFO, packet is lost
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      drop_cnt_o <= '0;
    end else if (push_pend && !chan_rdy_i[chan_q]) begin
      drop_cnt_o <= drop_cnt_o + 1'b1;
    end
  end

  a_vld_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(chan_vld_o));

  // A push only ever follows a second data word
  a_push_after_w1: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (chan_vld_o != '0) |-> $past(state == hss_mux_pkg::DIS_W1 && is_data));

endmodule

`default_nettype wire

// ==== verilog/hss_mux.sv ====
// Top level of the eight-channel serial link multiplexer
// Transmit channel FIFOs feeding the frame assembler
// Frame disassembler feeding the receive channel FIFOs

`timescale 1ns/1ps
`default_nettype none

module hss_mux (
  input  wire                               clk_i,
  input  wire                               rst_n_i,
  // Transmit packet streams
  input  wire hss_mux_pkg::pkt_t            tx_pkt_data_i [hss_mux_pkg::NUM_CHANS],
  input  wire [hss_mux_pkg::NUM_CHANS-1:0]  tx_pkt_vld_i,
  output wire [hss_mux_pkg::NUM_CHANS-1:0]  tx_pkt_rdy_o,
  // Receive packet streams
  output wire hss_mux_pkg::pkt_t            rx_pkt_data_o [hss_mux_pkg::NUM_CHANS],
  output wire [hss_mux_pkg::NUM_CHANS-1:0]  rx_pkt_vld_o,
  input  wire [hss_mux_pkg::NUM_CHANS-1:0]  rx_pkt_rdy_i,
  // Serial link, transmit
  output wire hss_mux_pkg::word_t           tx_data_o,
  output wire hss_mux_pkg::kflag_t          tx_kflags_o,
  // Serial link, receive
  input  wire hss_mux_pkg::word_t           rx_data_i,
  input  wire hss_mux_pkg::kflag_t          rx_kflags_i,
  input  wire                               rx_loss_of_sync_i,
  output wire [15:0]                        rx_drop_cnt_o
);

  wire hss_mux_pkg::pkt_t           fifo_tx_data [hss_mux_pkg::NUM_CHANS];
  wire [hss_mux_pkg::NUM_CHANS-1:0] fifo_tx_vld;
  wire [hss_mux_pkg::NUM_CHANS-1:0] fifo_tx_rdy;

  wire hss_mux_pkg::pkt_t           fifo_rx_data;
  wire [hss_mux_pkg::NUM_CHANS-1:0] fifo_rx_vld;
  wire [hss_mux_pkg::NUM_CHANS-1:0] fifo_rx_rdy;

  ////////////////////
  // Transmit path
  ////////////////////

  for (genvar c = 0; c < hss_mux_pkg::NUM_CHANS; c++) begin : g_tx_fifo
    pkt_fifo u_tx_fifo (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .in_data_i  (tx_pkt_data_i[c]),
      .in_vld_i   (tx_pkt_vld_i[c]),
      .in_rdy_o   (tx_pkt_rdy_o[c]),
      .out_data_o (fifo_tx_data[c]),
      .out_vld_o  (fifo_tx_vld[c]),
      .out_rdy_i  (fifo_tx_rdy[c])
    );
  end

  frame_assembler u_frame_assembler (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .chan_data_i (fifo_tx_data),
    .chan_vld_i  (fifo_tx_vld),
    .chan_rdy_o  (fifo_tx_rdy),
    .tx_data_o   (tx_data_o),
    .tx_kflags_o (tx_kflags_o)
  );

  ////////////////////
  // Receive path
  ////////////////////

  frame_disassembler u_frame_disassembler (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .rx_data_i         (rx_data_i),
    .rx_kflags_i       (rx_kflags_i),
    .rx_loss_of_sync_i (rx_loss_of_sync_i),
    .chan_data_o       (fifo_rx_data),
    .chan_vld_o        (fifo_rx_vld),
    .chan_rdy_i        (fifo_rx_rdy),
    .drop_cnt_o        (rx_drop_cnt_o)
  );

  // One shared data bus, the valid bit selects the FIFO
  for (genvar c = 0; c < hss_mux_pkg::NUM_CHANS; c++) begin : g_rx_fifo
    pkt_fifo u_rx_fifo (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .in_data_i  (fifo_rx_data),
      .in_vld_i   (fifo_rx_vld[c]),
      .in_rdy_o   (fifo_rx_rdy[c]),
      .out_data_o (rx_pkt_data_o[c]),
      .out_vld_o  (rx_pkt_vld_o[c]),
      .out_rdy_i  (rx_pkt_rdy_i[c])
    );
  end

endmodule

`default_nettype wire

// ==== tb/tb_hss_mux.sv ====
// Testbench for the eight-channel serial link multiplexer
// Table of stimulus rows with expected delivery and drop counts
// Loopback or direct receive source, per-channel expected queues
// Round-robin header monitor and cycle-limit timeout

`timescale 1ns/1ps
`default_nettype none

module tb_hss_mux;

  localparam int NUM_ROWS       = 19;
  localparam int TIMEOUT_CYCLES = NUM_ROWS * 40 + 200;
  localparam int SETTLE_CYCLES  = 8;

  // Row modes
  localparam logic [2:0] M_RR      = 3'd0;
  localparam logic [2:0] M_LOOP    = 3'd1;
  localparam logic [2:0] M_HOLD    = 3'd2;
  localparam logic [2:0] M_RELEASE = 3'd3;
  localparam logic [2:0] M_DIRECT  = 3'd4;
  localparam logic [2:0] M_LOS     = 3'd5;
  localparam logic [2:0] M_IDLE    = 3'd6;

  // Bytes 3 and 2 zero, idle tag, comma
  localparam hss_mux_pkg::word_t IDLE_WORD =
    {8'h00, 8'h00, hss_mux_pkg::IDLE_TAG, hss_mux_pkg::COMMA_BYTE};

  typedef struct packed {
    logic [2:0]  mode;
    logic [2:0]  chan;
    logic        deliver;
    logic [15:0] drop;
  } row_t;

  // Mode, channel, packet expected out, cumulative drop count
  localparam row_t ROWS [NUM_ROWS] = '{
    '{M_RR,      3'd0, 1'b1, 16'd0},
    '{M_LOOP,    3'd1, 1'b1, 16'd0},
    '{M_LOOP,    3'd6, 1'b1, 16'd0},
    '{M_LOOP,    3'd1, 1'b1, 16'd0},
    '{M_HOLD,    3'd3, 1'b1, 16'd0},
    '{M_HOLD,    3'd3, 1'b1, 16'd0},
    '{M_HOLD,    3'd3, 1'b1, 16'd0},
    '{M_HOLD,    3'd3, 1'b1, 16'd0},
    '{M_HOLD,    3'd3, 1'b0, 16'd1},
    '{M_LOOP,    3'd5, 1'b1, 16'd1},
    '{M_HOLD,    3'd3, 1'b0, 16'd2},
    '{M_RELEASE, 3'd3, 1'b0, 16'd2},
    '{M_LOOP,    3'd3, 1'b1, 16'd2},
    '{M_LOS,     3'd2, 1'b0, 16'd2},
    '{M_IDLE,    3'd4, 1'b0, 16'd2},
    '{M_DIRECT,  3'd4, 1'b1, 16'd2},
    '{M_LOS,     3'd7, 1'b0, 16'd2},
    '{M_DIRECT,  3'd7, 1'b1, 16'd2},
    '{M_LOOP,    3'd0, 1'b1, 16'd2}
  };

  logic clk;
  logic rst_n;

  hss_mux_pkg::pkt_t                tx_pkt_data [hss_mux_pkg::NUM_CHANS];
  logic [hss_mux_pkg::NUM_CHANS-1:0] tx_pkt_vld;
  wire  [hss_mux_pkg::NUM_CHANS-1:0] tx_pkt_rdy;
  wire hss_mux_pkg::pkt_t           rx_pkt_data [hss_mux_pkg::NUM_CHANS];
  wire  [hss_mux_pkg::NUM_CHANS-1:0] rx_pkt_vld;
  logic [hss_mux_pkg::NUM_CHANS-1:0] rx_pkt_rdy;
  wire hss_mux_pkg::word_t          tx_data;
  wire hss_mux_pkg::kflag_t         tx_kflags;
  hss_mux_pkg::word_t               rx_data;
  hss_mux_pkg::kflag_t              rx_kflags;
  logic                             rx_los;
  wire  [15:0]                      rx_drop_cnt;

  // Direct receive source
  logic                direct;
  hss_mux_pkg::word_t  dir_data;
  hss_mux_pkg::kflag_t dir_kflags;
  logic                dir_los;

  hss_mux_pkg::pkt_t exp_q [hss_mux_pkg::NUM_CHANS][$];
  hss_mux_pkg::pkt_t row_data [NUM_ROWS];

  int  errors    = 0;
  int  checks    = 0;
  int  cycles    = 0;
  int  rr_next   = 0;
  bit  rr_active = 1'b0;

  hss_mux DUT (
    .clk_i             (clk),
    .rst_n_i           (rst_n),
    .tx_pkt_data_i     (tx_pkt_data),
    .tx_pkt_vld_i      (tx_pkt_vld),
    .tx_pkt_rdy_o      (tx_pkt_rdy),
    .rx_pkt_data_o     (rx_pkt_data),
    .rx_pkt_vld_o      (rx_pkt_vld),
    .rx_pkt_rdy_i      (rx_pkt_rdy),
    .tx_data_o         (tx_data),
    .tx_kflags_o       (tx_kflags),
    .rx_data_i         (rx_data),
    .rx_kflags_i       (rx_kflags),
    .rx_loss_of_sync_i (rx_los),
    .rx_drop_cnt_o     (rx_drop_cnt)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // Receive word source with one register stage like a link pipeline
  always @(posedge clk) begin
    if (direct) begin
      rx_data   <= dir_data;
      rx_kflags <= dir_kflags;
      rx_los    <= dir_los;
    end else begin
      rx_data   <= tx_data;
      rx_kflags <= tx_kflags;
      rx_los    <= 1'b0;
    end
  end

  ////////////////////
  // Helpers
  ////////////////////

  task automatic check_cond(input bit ok, input string what);
    checks++;
    assert (ok) else begin
      $display("Fail %0t: %s", $time, what);
      errors++;
    end
  endtask

  // Comma in byte 0, channel in byte 1, upper bytes zero
  function automatic hss_mux_pkg::word_t make_header(input hss_mux_pkg::chan_t c);
    return {8'h00, 8'h00, 8'(c), hss_mux_pkg::COMMA_BYTE};
  endfunction

  // Channels with receive ready have nothing outstanding
  function automatic bit queues_drained();
    for (int c = 0; c < hss_mux_pkg::NUM_CHANS; c++) begin
      if (rx_pkt_rdy[c] && exp_q[c].size() != 0) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  task automatic check_idle;
    repeat (10) begin
      @(negedge clk);
      check_cond(tx_data == IDLE_WORD && tx_kflags == hss_mux_pkg::HDR_KFLAGS,
                 $sformatf("link word %h/%h, expected idle", tx_data, tx_kflags));
      check_cond(&tx_pkt_rdy, "transmit ready low after reset");
      check_cond(rx_pkt_vld == '0, "receive valid high after reset");
    end
  endtask

  task automatic push_tx(input hss_mux_pkg::chan_t c, input hss_mux_pkg::pkt_t d);
    @(posedge clk);
    tx_pkt_data[c] <= d;
    tx_pkt_vld[c]  <= 1'b1;
    do @(negedge clk); while (!tx_pkt_rdy[c]);
    @(posedge clk);
    tx_pkt_vld[c] <= 1'b0;
  endtask

  task automatic send_direct(input hss_mux_pkg::chan_t c, input hss_mux_pkg::pkt_t d,
                             input logic [2:0] mode);
    @(posedge clk);
    direct     <= 1'b1;
    dir_data   <= make_header(c);
    dir_kflags <= hss_mux_pkg::HDR_KFLAGS;
    dir_los    <= 1'b0;
    @(posedge clk);
    dir_data   <= d[63:32];
    dir_kflags <= '0;
    if (mode == M_LOS) begin
      @(posedge clk);
      dir_los  <= 1'b1;
      dir_data <= d[31:0];
      @(posedge clk);
      dir_los  <= 1'b0;
    end else if (mode == M_IDLE) begin
      @(posedge clk);
      dir_data   <= IDLE_WORD;
      dir_kflags <= hss_mux_pkg::HDR_KFLAGS;
    end
    @(posedge clk);
    dir_data   <= d[31:0];
    dir_kflags <= '0;
    @(posedge clk);
    dir_data   <= IDLE_WORD;
    dir_kflags <= hss_mux_pkg::HDR_KFLAGS;
  endtask

  // Wait for delivery and drops, then a quiet frame time
  task automatic wait_row(input logic [15:0] drop_target);
    do @(negedge clk); while (!(queues_drained() && rx_drop_cnt >= drop_target));
    repeat (SETTLE_CYCLES) @(negedge clk);
    check_cond(rx_drop_cnt == drop_target,
               $sformatf("drop count %0d, expected %0d", rx_drop_cnt, drop_target));
  endtask

  task automatic apply_row(input row_t row, input hss_mux_pkg::pkt_t d);
    hss_mux_pkg::pkt_t p;
    case (row.mode)
      M_RR: begin
        rr_next   = 0;
        rr_active = 1'b1;
        @(posedge clk);
        direct <= 1'b0;
        for (int c = 0; c < hss_mux_pkg::NUM_CHANS; c++) begin
          p = d ^ {8{8'(c)}};
          exp_q[c].push_back(p);
          tx_pkt_data[c] <= p;
        end
        tx_pkt_vld <= '1;
        do @(negedge clk); while (!(&tx_pkt_rdy));
        @(posedge clk);
        tx_pkt_vld <= '0;
        wait_row(row.drop);
        check_cond(rr_next == hss_mux_pkg::NUM_CHANS, "round-robin headers incomplete");
      end
      M_LOOP, M_HOLD: begin
        @(posedge clk);
        direct <= 1'b0;
        if (row.mode == M_HOLD) begin
          rx_pkt_rdy[row.chan] <= 1'b0;
        end
        if (row.deliver) begin
          exp_q[row.chan].push_back(d);
        end
        push_tx(row.chan, d);
        wait_row(row.drop);
      end
      M_RELEASE: begin
        @(posedge clk);
        rx_pkt_rdy[row.chan] <= 1'b1;
        wait_row(row.drop);
      end
      default: begin
        if (row.deliver) begin
          exp_q[row.chan].push_back(d);
        end
        send_direct(row.chan, d, row.mode);
        wait_row(row.drop);
      end
    endcase
  endtask

  ////////////////////
  // Monitors
  ////////////////////

  always @(negedge clk) begin : rx_monitor
    hss_mux_pkg::pkt_t want;
    if (rst_n) begin
      for (int c = 0; c < hss_mux_pkg::NUM_CHANS; c++) begin
        if (rx_pkt_vld[c] && rx_pkt_rdy[c]) begin
          assert (exp_q[c].size() != 0) else begin
            $display("Channel %0d delivered a packet that was never expected, at %0t",
                     c, $time);
            errors++;
          end
          if (exp_q[c].size() != 0) begin
            want = exp_q[c].pop_front();
            check_cond(rx_pkt_data[c] == want,
                       $sformatf("channel %0d data %h, expected %h", c, rx_pkt_data[c], want));
          end
        end
      end
    end
  end

  // Header channels must count upward from 0
  always @(negedge clk) begin : header_monitor
    if (rr_active && tx_kflags == hss_mux_pkg::HDR_KFLAGS &&
        tx_data[15:8] != hss_mux_pkg::IDLE_TAG) begin
      check_cond(tx_data == make_header(hss_mux_pkg::chan_t'(rr_next)),
                 $sformatf("header %h, expected channel %0d", tx_data, rr_next));
      rr_next++;
      if (rr_next == hss_mux_pkg::NUM_CHANS) begin
        rr_active = 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Checks: %0d, errors: %0d", checks, errors);
      $display(">>> FAIL");
      $finish;
    end
  end

  ////////////////////
  // Sequence
  ////////////////////

  initial begin
    int seed;
    seed       = 54941;
    rst_n      = 1'b0;
    tx_pkt_vld = '0;
    rx_pkt_rdy = '1;
    direct     = 1'b0;
    dir_data   = IDLE_WORD;
    dir_kflags = hss_mux_pkg::HDR_KFLAGS;
    dir_los    = 1'b0;
    rx_data    = IDLE_WORD;
    rx_kflags  = hss_mux_pkg::HDR_KFLAGS;
    rx_los     = 1'b0;
    for (int c = 0; c < hss_mux_pkg::NUM_CHANS; c++) begin
      tx_pkt_data[c] = '0;
    end
    for (int r = 0; r < NUM_ROWS; r++) begin
      row_data[r] = {$random(seed), $random(seed)};
    end

    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    check_idle();
    for (int r = 0; r < NUM_ROWS; r++) begin
      apply_row(ROWS[r], row_data[r]);
    end
    for (int c = 0; c < hss_mux_pkg::NUM_CHANS; c++) begin
      check_cond(exp_q[c].size() == 0,
                 $sformatf("channel %0d still waits for %0d packets", c, exp_q[c].size()));
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
verilog/hss_mux_pkg.sv
verilog/pkt_fifo.sv
verilog/frame_assembler.sv
verilog/frame_disassembler.sv
verilog/hss_mux.sv
tb/tb_hss_mux.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --assert --timing -Wno-fatal
TOP       = tb_hss_mux
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
PASS_MSG  = >>> PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
